//--- source/fetchControl.sv
`timescale 1ns/10ps

module fetchControl (
    input  logic              i_clock,               // Clock
    input  logic              i_rstN,                // Sync reset, active low
    input  logic              i_hazard,              // MEM stage owns the port
    input  logic              i_busy,                // Memory read in progress
    input  logic              i_stall,               // Decode cannot accept
    input  logic              i_redirect,            // Branch redirect strobe
    input  fetchPkg::InstAddr i_redirectPc,          // Redirect target
    input  logic              i_deliveredCompressed, // Word on the output was 16 bits
    output fetchPkg::InstReq  o_req,                 // Request to memory and timer
    output fetchPkg::InstAddr o_pc);                 // PC of the fetch in progress

    fetchPkg::FetchState state;
    fetchPkg::InstAddr   pc;
    fetchPkg::InstAddr   nextPc;
    logic                issue;

    // Port must be free of MEM accesses and of an older read
    assign issue  = (state == fetchPkg::Request) && !i_hazard && !i_busy && !i_redirect;
    assign nextPc = pc + (i_deliveredCompressed ? 32'd2 : 32'd4); // Step by delivered size

    assign o_req.addr = pc;
    assign o_req.re   = issue;
    assign o_pc       = pc;

    // ------------------------------------------------------------------------
    // Fetch sequencing
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            state <= fetchPkg::Idle;
            pc    <= fetchPkg::RESET_PC;
        end
        else if (i_redirect) begin
            state <= fetchPkg::Request;       // Redirect wins over any state
            pc    <= i_redirectPc;
        end
        else begin
            case (state)
                fetchPkg::Idle:
                    state <= fetchPkg::Request;
                fetchPkg::Request:
                    if (issue)
                        state <= fetchPkg::Wait;
                fetchPkg::Wait:
                    if (!i_busy) begin          // Word now sits in the IF/ID register
                        if (i_stall)
                            state <= fetchPkg::Hold;
                        else begin
                            pc    <= nextPc;
                            state <= fetchPkg::Request;
                        end
                    end
                fetchPkg::Hold:
                    if (!i_stall) begin         // Decode took the word
                        pc    <= nextPc;
                        state <= fetchPkg::Request;
                    end
                default:
                    state <= fetchPkg::Idle;
            endcase
        end
    end

    // Wait relies on busy rising right after the read strobe
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        o_req.re |=> i_busy);

    // Redirect targets come from outside and must keep the PC halfword aligned
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        !pc[0]);

endmodule

//--- source/fetchPkg.sv
package fetchPkg;

    // ------------------------------------------------------------------------
    // Memory geometry and timing
    // ------------------------------------------------------------------------

    localparam logic [8:0]  INST_MEM_HALFWORDS = 9'd256;        // Depth in halfwords
    localparam int          INST_INDEX_BITS    = $clog2(INST_MEM_HALFWORDS);
    localparam logic [1:0]  MEM_WAIT_CYCLES    = 2'd2;          // Wait states per read
    localparam logic [31:0] RESET_PC           = 32'h0000_0000; // First fetch address

    // RV32I major opcodes produced by the expander
    localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD   = 7'b0000011;
    localparam logic [6:0]  OPC_JAL    = 7'b1101111;
    localparam logic [6:0]  OPC_OP     = 7'b0110011;

    // ------------------------------------------------------------------------
    // Scalar types
    // ------------------------------------------------------------------------

    typedef logic [31:0]                InstAddr;  // Byte address
    typedef logic [31:0]                Inst;      // Full instruction word
    typedef logic [15:0]                CInst;     // Compressed instruction
    typedef logic [INST_INDEX_BITS-1:0] HalfIndex; // Halfword slot in the memory

    // Request towards the instruction memory
    typedef struct packed {
        InstAddr addr;  // Fetch address
        logic    re;    // Read strobe, one cycle
    } InstReq;

    // Response from the instruction memory
    typedef struct packed {
        Inst  inst;     // Halfwords at addr+2 and addr, low one first
        logic busy;     // Read still in progress
    } InstResp;

    // Result handed over to decode
    typedef struct packed {
        InstAddr pc;
        Inst     inst;       // Expanded when compressed
        logic    compressed; // Original word was 16 bits
    } FetchOut;

    typedef enum logic [1:0] {
        Idle,     // Leaving reset
        Request,  // Waiting for a free port, then issue
        Wait,     // Read in flight
        Hold      // Decode stalled on a delivered word
    } FetchState;

endpackage

//--- source/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit (
    input  logic               i_clock,       // Clock
    input  logic               i_rstN,        // Sync reset, active low
    input  logic               i_stall,       // Decode stall
    input  logic               i_redirect,    // Branch redirect strobe
    input  fetchPkg::InstAddr  i_redirectPc,  // Redirect target
    input  logic               i_memIsValid,  // Valid op in MEM
    input  logic               i_memRdEnable, // MEM reads memory
    input  logic               i_memWrEnable, // MEM writes memory
    input  logic               i_loadEn,      // Program load strobe
    input  fetchPkg::HalfIndex i_loadAddr,    // Program load slot
    input  fetchPkg::CInst     i_loadData,    // Program load halfword
    output logic               o_hazard,      // Fetch blocked by MEM
    output logic               o_instValid,   // Word ready for decode
    output fetchPkg::FetchOut  o_out);        // PC, instruction, compressed flag

    fetchPkg::InstReq  req;
    fetchPkg::InstResp resp;
    fetchPkg::InstAddr pc;
    logic              busy;
    logic              done;

    fetchControl control (
        .i_clock               (i_clock),
        .i_rstN                (i_rstN),
        .i_hazard              (o_hazard),
        .i_busy                (busy),
        .i_stall               (i_stall),
        .i_redirect            (i_redirect),
        .i_redirectPc          (i_redirectPc),
        .i_deliveredCompressed (o_out.compressed),
        .o_req                 (req),
        .o_pc                  (pc));

    memWaitTimer timer (
        .i_clock (i_clock),
        .i_rstN  (i_rstN),
        .i_start (req.re),      // Each read starts the wait states
        .o_busy  (busy),
        .o_done  (done));

    instRom rom (
        .i_clock    (i_clock),
        .i_req      (req),
        .i_busy     (busy),
        .i_loadEn   (i_loadEn),
        .i_loadAddr (i_loadAddr),
        .i_loadData (i_loadData),
        .o_resp     (resp));

    stageIf stage (
        .i_clock       (i_clock),
        .i_rstN        (i_rstN),
        .i_resp        (resp),
        .i_done        (done),
        .i_pc          (pc),
        .i_stall       (i_stall),
        .i_redirect    (i_redirect),
        .i_memIsValid  (i_memIsValid),
        .i_memRdEnable (i_memRdEnable),
        .i_memWrEnable (i_memWrEnable),
        .o_hazard      (o_hazard),
        .o_out         (o_out),
        .o_instValid   (o_instValid));

endmodule

//--- source/instExpander.sv
`timescale 1ns/10ps

module instExpander (
    input  fetchPkg::Inst i_inst,          // Fetched word
    output fetchPkg::Inst o_inst,          // 32-bit form
    output logic          o_isCompressed); // Low halfword is an RVC encoding

    fetchPkg::CInst c;
    fetchPkg::Inst  expanded;
    logic [4:0]     rdFull;
    logic [4:0]     rs2Full;
    logic [4:0]     rdPrime;
    logic [4:0]     rs1Prime;
    logic [11:0]    immCi;
    logic [11:0]    immLw;
    logic [20:0]    offJ;

    assign c              = i_inst[15:0];
    assign o_isCompressed = (i_inst[1:0] != 2'b11);

    // ------------------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------------------

    assign rdFull   = c[11:7];
    assign rs2Full  = c[6:2];
    assign rdPrime  = {2'b01, c[4:2]};  // x8..x15
    assign rs1Prime = {2'b01, c[9:7]};

    // CI immediate, sign extended
    assign immCi = {{6{c[12]}}, c[12], c[6:2]};

    // C.LW offset, word scaled and zero extended
    assign immLw = {5'd0, c[5], c[12:10], c[6], 2'b00};

    // C.J offset bits are scattered across the encoding
    assign offJ = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11],
                   c[5:3], 1'b0};

    // ------------------------------------------------------------------------
    // Expansion table
    // ------------------------------------------------------------------------

    always_comb begin
        expanded = '0;                  // Unsupported encodings
        case ({c[15:13], c[1:0]})
            5'b000_01:                  // C.ADDI
                expanded = {immCi, rdFull, 3'b000, rdFull, fetchPkg::OPC_OP_IMM};
            5'b010_01:                  // C.LI
                expanded = {immCi, 5'd0, 3'b000, rdFull, fetchPkg::OPC_OP_IMM};
            5'b010_00:                  // C.LW
                expanded = {immLw, rs1Prime, 3'b010, rdPrime, fetchPkg::OPC_LOAD};
            5'b101_01:                  // C.J
                expanded = {offJ[20], offJ[10:1], offJ[11], offJ[19:12], 5'd0,
                            fetchPkg::OPC_JAL};
            5'b100_10: begin
                if (rs2Full != 5'd0) begin          // rs2 zero is JR, JALR or EBREAK
                    if (c[12])                      // C.ADD
                        expanded = {7'd0, rs2Full, rdFull, 3'b000, rdFull,
                                    fetchPkg::OPC_OP};
                    else                            // C.MV
                        expanded = {7'd0, rs2Full, 5'd0, 3'b000, rdFull,
                                    fetchPkg::OPC_OP};
                end
            end
            default:
                expanded = '0;
        endcase
    end

    assign o_inst = o_isCompressed ? expanded : i_inst; // Full words pass untouched

endmodule

//--- source/instRom.sv
`timescale 1ns/10ps

module instRom (
    input  logic               i_clock,    // Clock
    input  fetchPkg::InstReq   i_req,      // Fetch request
    input  logic               i_busy,     // From the wait timer
    input  logic               i_loadEn,   // Program load strobe
    input  fetchPkg::HalfIndex i_loadAddr, // Halfword slot to write
    input  fetchPkg::CInst     i_loadData, // Halfword to write
    output fetchPkg::InstResp  o_resp);    // Word and busy back to the stage

    fetchPkg::CInst     mem [0:fetchPkg::INST_MEM_HALFWORDS-1]; // Program store
    fetchPkg::HalfIndex rdIdx;
    fetchPkg::HalfIndex rdIdxNext;

    // ------------------------------------------------------------------------
    // Program load
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (i_loadEn)
            mem[i_loadAddr] <= i_loadData;
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    // Byte address to halfword slot
    assign rdIdx     = i_req.addr[fetchPkg::INST_INDEX_BITS:1];
    assign rdIdxNext = rdIdx + 1'b1;    // Wraps at the top of the memory

    assign o_resp.inst = {mem[rdIdxNext], mem[rdIdx]}; // Low halfword first
    assign o_resp.busy = i_busy;

    // Loading happens only while the fetch side is held in reset
    assert property (@(posedge i_clock)
        i_req.re |-> !i_loadEn);

endmodule

//--- source/memWaitTimer.sv
`timescale 1ns/10ps

module memWaitTimer (
    input  logic i_clock,  // Clock
    input  logic i_rstN,   // Sync reset, active low
    input  logic i_start,  // Read strobe
    output logic o_busy,   // Wait states running
    output logic o_done);  // Last wait state, data valid

    logic [$bits(fetchPkg::MEM_WAIT_CYCLES)-1:0] count;

    // Load on start, then count down to zero
    always_ff @(posedge i_clock) begin
        if (!i_rstN)
            count <= '0;
        else if (i_start)
            count <= fetchPkg::MEM_WAIT_CYCLES;
        else if (count != '0)
            count <= count - 1'b1;
    end

    assign o_busy = (count != '0);
    assign o_done = (count == 1);       // Completion cycle

    // Memory is unpipelined, the controller must wait for idle
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        i_start |-> !o_busy);

endmodule

//--- source/stageIf.sv
`timescale 1ns/10ps

module stageIf (
    input  logic              i_clock,       // Clock
    input  logic              i_rstN,        // Sync reset, active low
    input  fetchPkg::InstResp i_resp,        // Memory response
    input  logic              i_done,        // Completion cycle
    input  fetchPkg::InstAddr i_pc,          // PC of the fetch in flight
    input  logic              i_stall,       // Decode stall
    input  logic              i_redirect,    // Branch redirect strobe
    input  logic              i_memIsValid,  // Valid op in MEM
    input  logic              i_memRdEnable, // MEM reads memory
    input  logic              i_memWrEnable, // MEM writes memory
    output logic              o_hazard,      // Port taken by MEM
    output fetchPkg::FetchOut o_out,         // IF/ID register
    output logic              o_instValid);  // o_out holds a live word

    fetchPkg::Inst expInst;
    logic          expCompressed;
    logic          discard;                  // Read in flight belongs to the old path
    logic          load;

    // Shared port hazard
    assign o_hazard = i_memIsValid & (i_memRdEnable | i_memWrEnable);

    instExpander expander (
        .i_inst         (i_resp.inst),
        .o_inst         (expInst),
        .o_isCompressed (expCompressed));

    assign load = i_done & ~discard & ~i_redirect;

    // ------------------------------------------------------------------------
    // IF/ID register
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            o_instValid <= 1'b0;
            discard     <= 1'b0;
        end
        else begin
            if (i_redirect)
                discard <= i_resp.busy & ~i_done; // Drop the read still counting
            else if (i_done)
                discard <= 1'b0;

            if (i_redirect)
                o_instValid <= 1'b0;
            else if (load)
                o_instValid <= 1'b1;
            else if (!i_stall)
                o_instValid <= 1'b0;              // Taken by decode
        end
    end

    always_ff @(posedge i_clock) begin
        if (load) begin
            o_out.pc         <= i_pc;
            o_out.inst       <= expInst;
            o_out.compressed <= expCompressed;
        end
    end

    // Controller stays in Hold, so nothing new lands under a stall
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        (o_instValid && i_stall && !i_redirect) |=> (o_instValid && $stable(o_out)));

endmodule

//--- tb.f
source/fetchPkg.sv
source/fetchControl.sv
source/memWaitTimer.sv
source/instRom.sv
source/instExpander.sv
source/stageIf.sv
source/fetchUnit.sv
tests/fetchUnitTb.sv

//--- tests/fetchUnitTb.sv
`timescale 1ns/10ps

module fetchUnitTb;

    logic               i_clock = 1'b0;
    logic               i_rstN;
    logic               i_stall;               // Decode back-pressure
    logic               i_redirect;
    fetchPkg::InstAddr  i_redirectPc;
    logic               i_memIsValid;          // MEM stage levels behind the hazard
    logic               i_memRdEnable;
    logic               i_memWrEnable;
    logic               i_loadEn;
    fetchPkg::HalfIndex i_loadAddr;
    fetchPkg::CInst     i_loadData;
    logic               o_hazard;
    logic               o_instValid;
    fetchPkg::FetchOut  o_out;

    fetchPkg::CInst    prog [0:fetchPkg::INST_MEM_HALFWORDS-1]; // Copy of the loaded program
    fetchPkg::InstAddr expPc;                  // Pc of the next word decode should take
    logic [31:0]       lcgState = 32'd65419;
    int                cycle = 0;              // Watchdog counter
    int                relCycles = 0;          // Cycles since reset release
    int                deliveries = 0;
    int                errors = 0;

    // Funct3 and quadrant of C.ADDI, C.LI, C.LW, C.J, C.MV, C.ADD and the unsupported C.SW
    logic [4:0] rowKey [0:6] = '{5'b000_01, 5'b010_01, 5'b010_00, 5'b101_01,
                                 5'b100_10, 5'b100_10, 5'b110_00};

    fetchUnit fetchUnit_i (.*);

    always #50 i_clock = ~i_clock;

    // LCG step returning the upper half
    function automatic logic [15:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    task automatic flagError(input string msg);
        errors++;
        $display("FAILED at %0t ns: %s", $time, msg);
    endtask

    // Expected 32-bit form of a compressed word from the table rows
    function automatic fetchPkg::Inst expandRef(input fetchPkg::CInst c);
        logic [11:0] imm;
        logic [20:0] off;
        imm = {{7{c[12]}}, c[6:2]};                                  // CI immediate
        off = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
        case ({c[15:13], c[1:0]})
            5'b000_01: return {imm, c[11:7], 3'b000, c[11:7], 7'h13};    // addi rd,rd,imm
            5'b010_01: return {imm, 5'd0, 3'b000, c[11:7], 7'h13};       // addi rd,x0,imm
            5'b010_00: return {5'd0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7], 3'b010,
                               2'b01, c[4:2], 7'h03};                   // lw
            5'b101_01: return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'h6f};
            5'b100_10: return (c[6:2] == 5'd0) ? 32'd0 :
                              {7'd0, c[6:2], c[12] ? c[11:7] : 5'd0, 3'b000, c[11:7], 7'h33};
            default:   return 32'd0;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Reference model with one check per word that decode takes
    // ------------------------------------------------------------------------

    always @(posedge i_clock) begin : model
        fetchPkg::FetchOut want;
        cycle++;
        if (i_rstN) begin
            if (o_instValid && !i_stall) begin
                want.pc         = expPc;
                want.inst       = {prog[expPc[8:1] + 8'd1], prog[expPc[8:1]]}; // Wraps at the top
                want.compressed = (want.inst[1:0] != 2'b11);
                if (want.compressed)
                    want.inst = expandRef(want.inst[15:0]);
                assert (o_out === want)
                    else flagError($sformatf("got pc %h inst %h c %b, expected pc %h inst %h c %b",
                        o_out.pc, o_out.inst, o_out.compressed, want.pc, want.inst, want.compressed));
                if (deliveries == 0)
                    assert (relCycles == fetchPkg::MEM_WAIT_CYCLES + 2)
                        else flagError($sformatf("first word %0d cycles after reset", relCycles));
                expPc = expPc + (want.compressed ? 32'd2 : 32'd4);
                deliveries++;
            end
            if (i_redirect)
                expPc = i_redirectPc;   // Next word comes from the target
            relCycles++;
        end
    end

    // Valid stays low once reset has taken effect
    assert property (@(posedge i_clock) (!i_rstN && cycle > 0) |-> !o_instValid)
        else flagError("o_instValid high during reset");

    assert property (@(posedge i_clock)
        o_hazard == (i_memIsValid && (i_memRdEnable || i_memWrEnable)))
        else flagError("o_hazard does not follow the MEM-stage levels");

    // Decode sees the same word for as long as it stalls
    assert property (@(posedge i_clock) disable iff (!i_rstN)
        (o_instValid && i_stall && !i_redirect) |=> (o_instValid && $stable(o_out)))
        else flagError("o_out or o_instValid changed under stall");

    assert property (@(posedge i_clock) disable iff (!i_rstN)
        i_redirect |=> !o_instValid)
        else flagError("o_instValid still high after a redirect");

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    initial begin
        int          idx;
        int          kind;
        logic [15:0] r;
        i_rstN        = 1'b0;
        i_stall       = 1'b0;
        i_redirect    = 1'b0;
        i_redirectPc  = '0;
        i_memIsValid  = 1'b0;
        i_memRdEnable = 1'b0;
        i_memWrEnable = 1'b0;
        i_loadEn      = 1'b0;
        i_loadAddr    = '0;
        i_loadData    = '0;
        expPc         = fetchPkg::RESET_PC;

        // Random program mixing full words with every table row
        idx = 0;
        while (idx < fetchPkg::INST_MEM_HALFWORDS) begin
            kind = nextRand() % 10;                 // 7 to 9 give a full word
            r    = nextRand();
            if (kind > 6 && idx < fetchPkg::INST_MEM_HALFWORDS - 1) begin
                prog[idx]     = r | 16'h0003;       // Low half first
                prog[idx + 1] = nextRand();
                idx += 2;
            end
            else begin
                kind = kind % 7;
                if (kind == 4 || kind == 5)
                    r = {r[15:11], kind == 5, r[9:1], 1'b1};   // Keeps rs2 off x0
                prog[idx] = {rowKey[kind][4:2], r[10:0], rowKey[kind][1:0]};
                idx++;
            end
        end

        // Program goes in under reset at one halfword per cycle
        for (int i = 0; i < fetchPkg::INST_MEM_HALFWORDS; i++) begin
            @(posedge i_clock);
            #5;
            i_loadEn   = 1'b1;
            i_loadAddr = fetchPkg::HalfIndex'(i);
            i_loadData = prog[i];
        end
        @(posedge i_clock);
        #5;
        i_loadEn = 1'b0;
        repeat (8) @(posedge i_clock);             // Plain reset cycles
        #5;
        i_rstN = 1'b1;
        wait (deliveries != 0);                    // First word with quiet inputs

        // Random stall, MEM traffic and the odd redirect
        while (deliveries < 120) begin
            @(posedge i_clock);
            #5;
            i_stall       = (nextRand() % 3) == 0;
            i_memIsValid  = (nextRand() % 2) == 0;
            i_memRdEnable = (nextRand() % 2) == 0;
            i_memWrEnable = (nextRand() % 4) == 0;
            i_redirect    = (nextRand() % 20) == 0;
            i_redirectPc  = (nextRand() & 16'h00ff) << 1;  // Halfword aligned inside the program
        end
        i_stall    = 1'b0;
        i_redirect = 1'b0;
        repeat (2) @(posedge i_clock);
        $display("Deliveries %0d, errors %0d", deliveries, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // Watchdog allowing twenty cycles per program halfword
    initial begin
        wait (cycle >= fetchPkg::INST_MEM_HALFWORDS * 20);
        $display("Run timed out after %0d cycles before all words were delivered", cycle);
        $display("Deliveries %0d, errors %0d", deliveries, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule
